// File: hdl/ibuf_defs.svh
`ifndef IBUF_DEFS_SVH
`define IBUF_DEFS_SVH

// fetch and issue width, tied to the slot-pair rules
`define IBUF_LANES 2

// entries per lane, power of two of 2 or more
`define IBUF_DEPTH 8

`define IBUF_PTR_W $clog2(`IBUF_DEPTH)

`endif

// File: hdl/fetch_pkg.sv
package fetch_pkg;

    // one slot of a fetch group as offered by the icache
    typedef struct packed {
        logic [31:0] inst;
        logic [31:0] pc;
        logic [5:0]  exc_code;
    } fetch_slot_t;

    // per-slot prediction from the bpu
    typedef struct packed {
        logic is_branch;
        logic pred_taken;
    } bpu_hint_t;

endpackage

// File: hdl/issue_pkg.sv
package issue_pkg;

    // prediction carried along to decode
    typedef struct packed {
        logic        is_branch;
        logic        pred_taken;
        logic [31:0] pred_target;
    } branch_info_t;

    // one stored lane entry
    // valid low marks a bubble or a wrong-path slot
    typedef struct packed {
        logic                   valid;
        fetch_pkg::fetch_slot_t slot;
        branch_info_t           branch;
    } ibuf_entry_t;

    // what decode sees per lane
    typedef struct packed {
        logic        issued;
        ibuf_entry_t entry;
    } issue_slot_t;

endpackage

// File: hdl/ibuf_fifo.sv
`include "ibuf_defs.svh"

module ibuf_fifo #(
    parameter int DEPTH = `IBUF_DEPTH
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  flush_i,
    input  logic                  push_i,
    input  issue_pkg::ibuf_entry_t push_entry_i,
    input  logic                  pop_i,
    output issue_pkg::ibuf_entry_t head_o,
    output logic                  full_o,
    output logic                  empty_o
);

    localparam int PTR_W = $clog2(DEPTH);

    issue_pkg::ibuf_entry_t mem [DEPTH];

    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W:0]   count;
    logic [PTR_W:0]   count_next;
    logic             do_push;
    logic             do_pop;

    assign do_push = push_i && !full_o;
    assign do_pop  = pop_i && !empty_o;

    always_comb begin
        count_next = count;
        if (do_push && !do_pop) begin
            count_next = count + 1'b1;
        end else if (do_pop && !do_push) begin
            count_next = count - 1'b1;
        end
    end

    // pointers and levels
    always_ff @(posedge clk) begin
        if (rst || flush_i) begin
            rd_ptr  <= '0;
            wr_ptr  <= '0;
            count   <= '0;
            full_o  <= 1'b0;
            empty_o <= 1'b1;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count   <= count_next;
            full_o  <= (count_next == DEPTH[PTR_W:0]);
            empty_o <= (count_next == '0);
        end
    end

    // storage
    always_ff @(posedge clk) begin
        if (do_push && !flush_i) begin
            mem[wr_ptr] <= push_entry_i;
        end
    end

    // show-ahead head
    assign head_o = mem[rd_ptr];

endmodule

// File: hdl/ibuf_push_ctrl.sv
`include "ibuf_defs.svh"

module ibuf_push_ctrl (
    input  logic                                         clk,
    input  logic                                         rst,
    input  fetch_pkg::fetch_slot_t [`IBUF_LANES-1:0]    fetch_slots_i,
    input  logic                   [`IBUF_LANES-1:0]    fetch_en_i,
    input  fetch_pkg::bpu_hint_t   [`IBUF_LANES-1:0]    bpu_hints_i,
    input  logic                   [31:0]               pred_target_i,
    input  logic                                         stall_i,
    input  logic                                         flush_i,
    input  logic                   [`IBUF_LANES-1:0]    lane_full_i,
    output logic                   [`IBUF_LANES-1:0]    push_en_o,
    output issue_pkg::ibuf_entry_t [`IBUF_LANES-1:0]    push_entry_o
);

    logic [`IBUF_LANES-1:0] taken;
    logic [`IBUF_LANES-1:0] bubble;
    logic                   shadow_q;

    always_comb begin
        for (int i = 0; i < `IBUF_LANES; i++) begin
            taken[i] = bpu_hints_i[i].is_branch && bpu_hints_i[i].pred_taken;
        end
    end

    // a later slot is a bubble once an earlier slot is taken
    always_comb begin
        bubble[0] = 1'b0;
        for (int i = 1; i < `IBUF_LANES; i++) begin
            bubble[i] = bubble[i-1] || taken[i-1];
        end
    end

    always_comb begin
        for (int i = 0; i < `IBUF_LANES; i++) begin
            push_en_o[i] = fetch_en_i[i] && !stall_i && !lane_full_i[i] && !flush_i;
        end
    end

    always_comb begin
        for (int i = 0; i < `IBUF_LANES; i++) begin
            push_entry_o[i].valid              = !shadow_q && !bubble[i];
            push_entry_o[i].slot               = fetch_slots_i[i];
            push_entry_o[i].branch.is_branch   = bpu_hints_i[i].is_branch;
            push_entry_o[i].branch.pred_taken  = bpu_hints_i[i].pred_taken;
            push_entry_o[i].branch.pred_target = pred_target_i;
        end
    end

    // one-group fetch shadow behind a predicted-taken branch
    always_ff @(posedge clk) begin
        if (rst || flush_i) begin
            shadow_q <= 1'b0;
        end else if (|push_en_o) begin
            shadow_q <= |(push_en_o & taken);
        end
    end

endmodule

// File: hdl/ibuf_pop_ctrl.sv
`include "ibuf_defs.svh"

module ibuf_pop_ctrl (
    input  issue_pkg::ibuf_entry_t [`IBUF_LANES-1:0] head_i,
    input  logic                   [`IBUF_LANES-1:0] lane_empty_i,
    input  logic                   [`IBUF_LANES-1:0] send_en_i,
    input  logic                                      pause_i,
    input  logic                                      pause_decoder_i,
    output logic                   [`IBUF_LANES-1:0] pop_en_o,
    output issue_pkg::issue_slot_t [`IBUF_LANES-1:0] issue_slots_o
);

    logic hold;

    // either pause freezes all lanes
    assign hold = pause_i || pause_decoder_i;

    always_comb begin
        for (int i = 0; i < `IBUF_LANES; i++) begin
            pop_en_o[i] = send_en_i[i] && !lane_empty_i[i] && !hold;
        end
    end

    always_comb begin
        for (int i = 0; i < `IBUF_LANES; i++) begin
            if (pop_en_o[i]) begin
                issue_slots_o[i].issued = 1'b1;
                issue_slots_o[i].entry  = head_i[i];
            end else begin
                issue_slots_o[i] = '0;
            end
        end
    end

endmodule

// File: hdl/inst_buffer.sv
`include "ibuf_defs.svh"

module inst_buffer (
    input  logic                                      clk,
    input  logic                                      rst,
    input  fetch_pkg::fetch_slot_t [`IBUF_LANES-1:0] fetch_slots_i,
    input  logic                   [`IBUF_LANES-1:0] fetch_en_i,
    input  fetch_pkg::bpu_hint_t   [`IBUF_LANES-1:0] bpu_hints_i,
    input  logic                   [31:0]            pred_target_i,
    input  logic                                      stall_i,
    input  logic                                      flush_i,
    input  logic                                      pause_i,
    input  logic                                      pause_decoder_i,
    input  logic                   [`IBUF_LANES-1:0] send_en_i,
    output issue_pkg::issue_slot_t [`IBUF_LANES-1:0] issue_slots_o,
    output logic                                      full_o
);

    logic                   [`IBUF_LANES-1:0] push_en;
    issue_pkg::ibuf_entry_t [`IBUF_LANES-1:0] push_entry;
    logic                   [`IBUF_LANES-1:0] pop_en;
    issue_pkg::ibuf_entry_t [`IBUF_LANES-1:0] head;
    logic                   [`IBUF_LANES-1:0] lane_full;
    logic                   [`IBUF_LANES-1:0] lane_empty;

    assign full_o = |lane_full;

    ibuf_push_ctrl push_ctrl_inst (
        .clk           (clk),
        .rst           (rst),
        .fetch_slots_i (fetch_slots_i),
        .fetch_en_i    (fetch_en_i),
        .bpu_hints_i   (bpu_hints_i),
        .pred_target_i (pred_target_i),
        .stall_i       (stall_i),
        .flush_i       (flush_i),
        .lane_full_i   (lane_full),
        .push_en_o     (push_en),
        .push_entry_o  (push_entry)
    );

    for (genvar i = 0; i < `IBUF_LANES; i++) begin : gen_lane
        ibuf_fifo #(
            .DEPTH (`IBUF_DEPTH)
        ) fifo_inst (
            .clk          (clk),
            .rst          (rst),
            .flush_i      (flush_i),
            .push_i       (push_en[i]),
            .push_entry_i (push_entry[i]),
            .pop_i        (pop_en[i]),
            .head_o       (head[i]),
            .full_o       (lane_full[i]),
            .empty_o      (lane_empty[i])
        );
    end

    ibuf_pop_ctrl pop_ctrl_inst (
        .head_i          (head),
        .lane_empty_i    (lane_empty),
        .send_en_i       (send_en_i),
        .pause_i         (pause_i),
        .pause_decoder_i (pause_decoder_i),
        .pop_en_o        (pop_en),
        .issue_slots_o   (issue_slots_o)
    );

endmodule

// File: bench/inst_buffer_model.svh
`ifndef INST_BUFFER_MODEL_SVH
`define INST_BUFFER_MODEL_SVH

// reference lane contents, head at index 0
issue_pkg::ibuf_entry_t model_q [`IBUF_LANES][$];
logic                   model_shadow;
logic [31:0]            rng_state;

function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
endfunction

function automatic logic [31:0] next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
endfunction

function automatic logic is_taken(input fetch_pkg::bpu_hint_t h);
    return h.is_branch && h.pred_taken;
endfunction

// entry as the buffer should store it for one lane
function automatic issue_pkg::ibuf_entry_t expected_entry(
    input int                     lane,
    input fetch_pkg::fetch_slot_t slot,
    input fetch_pkg::bpu_hint_t   hint,
    input fetch_pkg::bpu_hint_t   slot0_hint,
    input logic [31:0]            target,
    input logic                   shadow
);
    issue_pkg::ibuf_entry_t e;
    e.valid              = !shadow && !(lane == 1 && is_taken(slot0_hint));
    e.slot               = slot;
    e.branch.is_branch   = hint.is_branch;
    e.branch.pred_taken  = hint.pred_taken;
    e.branch.pred_target = target;
    return e;
endfunction

function automatic int model_entries();
    int total;
    total = 0;
    for (int i = 0; i < `IBUF_LANES; i++) begin
        total += model_q[i].size();
    end
    return total;
endfunction

`endif

// File: bench/inst_buffer_tb.sv
`include "ibuf_defs.svh"

module inst_buffer_tb;

    typedef struct packed {
        logic stall;
        logic flush;
        logic pause;
        logic pause_decoder;
    } ctrl_t;

    localparam fetch_pkg::bpu_hint_t hint_none      = 2'b00;
    localparam fetch_pkg::bpu_hint_t hint_taken     = 2'b11;
    localparam fetch_pkg::bpu_hint_t hint_not_taken = 2'b10;
    localparam ctrl_t ctrl_idle  = '0;
    localparam ctrl_t ctrl_stall = 4'b1000;
    localparam ctrl_t ctrl_flush = 4'b0100;

    logic                                     clk;
    logic                                     rst;
    fetch_pkg::fetch_slot_t [`IBUF_LANES-1:0] fetch_slots;
    logic                   [`IBUF_LANES-1:0] fetch_en;
    fetch_pkg::bpu_hint_t   [`IBUF_LANES-1:0] bpu_hints;
    logic                   [31:0]            pred_target;
    ctrl_t                                    ctrl;
    logic                   [`IBUF_LANES-1:0] send_en;
    issue_pkg::issue_slot_t [`IBUF_LANES-1:0] issue_slots;
    logic                                     full;
    int                                       checked_count;

    `include "inst_buffer_model.svh"

    inst_buffer inst_buffer_inst (
        .clk             (clk),
        .rst             (rst),
        .fetch_slots_i   (fetch_slots),
        .fetch_en_i      (fetch_en),
        .bpu_hints_i     (bpu_hints),
        .pred_target_i   (pred_target),
        .stall_i         (ctrl.stall),
        .flush_i         (ctrl.flush),
        .pause_i         (ctrl.pause),
        .pause_decoder_i (ctrl.pause_decoder),
        .send_en_i       (send_en),
        .issue_slots_o   (issue_slots),
        .full_o          (full)
    );

    always #2 clk = ~clk;

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("TEST FAIL");
        $fatal(1);
    endtask

    function automatic fetch_pkg::fetch_slot_t random_slot();
        fetch_pkg::fetch_slot_t s;
        logic [31:0]            r;
        s.inst = next_rand();
        r = next_rand();
        s.pc = {r[31:2], 2'b00};
        r = next_rand();
        // mostly no exception
        s.exc_code = (r[7:0] < 8'd20) ? r[13:8] : 6'd0;
        return s;
    endfunction

    task automatic drive_cycle(
        input logic [`IBUF_LANES-1:0] en,
        input fetch_pkg::bpu_hint_t   h0,
        input fetch_pkg::bpu_hint_t   h1,
        input logic [`IBUF_LANES-1:0] send,
        input ctrl_t                  c
    );
        @(posedge clk);
        fetch_slots[0] <= random_slot();
        fetch_slots[1] <= random_slot();
        fetch_en       <= en;
        bpu_hints[0]   <= h0;
        bpu_hints[1]   <= h1;
        pred_target    <= next_rand();
        send_en        <= send;
        ctrl           <= c;
    endtask

    task automatic drive_random();
        logic [31:0] r;
        ctrl_t       c;
        logic [1:0]  send;
        r = next_rand();
        c.stall         = (r[2:0] == 3'd0);
        c.flush         = (r[8:3] == 6'd0);
        c.pause         = (r[11:9] == 3'd0);
        c.pause_decoder = (r[14:12] == 3'd0);
        // some stretches drain slowly so the lanes fill up
        send = r[25] ? r[22:21] : {r[23] & r[24], r[21] & r[22]};
        drive_cycle(r[16:15], fetch_pkg::bpu_hint_t'(r[18:17]),
                    fetch_pkg::bpu_hint_t'(r[20:19]), send, c);
    endtask

    task automatic drain_lanes(input int limit);
        int n;
        n = 0;
        do begin
            if (n == limit) begin
                stop_with_error($sformatf("timeout: lanes not drained after %0d cycles", limit));
            end
            n++;
            drive_cycle(2'b00, hint_none, hint_none, 2'b11, ctrl_idle);
            @(negedge clk);
        end while (model_entries() != 0);
    endtask

    task automatic fill_until_full(input int limit);
        int n;
        n = 0;
        do begin
            if (n == limit) begin
                stop_with_error($sformatf("timeout: full_o did not rise in %0d cycles", limit));
            end
            n++;
            drive_cycle(2'b11, hint_none, hint_not_taken, 2'b00, ctrl_idle);
            @(negedge clk);
        end while (!full);
    endtask

    // comparison against the reference lanes, then model update
    always @(posedge clk) begin
        logic [`IBUF_LANES-1:0] exp_pop;
        logic [`IBUF_LANES-1:0] exp_push;
        logic                   exp_full;
        logic                   any_taken;
        issue_pkg::issue_slot_t exp_slot;
        if (rst) begin
            for (int i = 0; i < `IBUF_LANES; i++) begin
                model_q[i].delete();
            end
            model_shadow = 1'b0;
        end else begin
            exp_full = 1'b0;
            for (int i = 0; i < `IBUF_LANES; i++) begin
                if (model_q[i].size() == `IBUF_DEPTH) begin
                    exp_full = 1'b1;
                end
            end
            assert (full == exp_full) else begin
                stop_with_error($sformatf("[FAIL] full_o got %h expected %h", full, exp_full));
            end
            for (int i = 0; i < `IBUF_LANES; i++) begin
                exp_pop[i] = send_en[i] && model_q[i].size() != 0 && !ctrl.pause &&
                             !ctrl.pause_decoder;
                exp_push[i] = fetch_en[i] && !ctrl.stall && model_q[i].size() < `IBUF_DEPTH;
                exp_slot = '0;
                if (exp_pop[i]) begin
                    exp_slot.issued = 1'b1;
                    exp_slot.entry  = model_q[i][0];
                end
                assert (issue_slots[i] == exp_slot) else begin
                    stop_with_error($sformatf("[FAIL] issue_slots_o[%0d] got %h expected %h",
                                              i, issue_slots[i], exp_slot));
                end
            end
            for (int i = 0; i < `IBUF_LANES; i++) begin
                if (exp_pop[i]) begin
                    void'(model_q[i].pop_front());
                    checked_count++;
                end
            end
            if (ctrl.flush) begin
                for (int i = 0; i < `IBUF_LANES; i++) begin
                    model_q[i].delete();
                end
                model_shadow = 1'b0;
            end else begin
                any_taken = 1'b0;
                for (int i = 0; i < `IBUF_LANES; i++) begin
                    if (exp_push[i]) begin
                        model_q[i].push_back(expected_entry(i, fetch_slots[i], bpu_hints[i],
                                                            bpu_hints[0], pred_target,
                                                            model_shadow));
                        any_taken = any_taken || is_taken(bpu_hints[i]);
                    end
                end
                if (|exp_push) begin
                    model_shadow = any_taken;
                end
            end
        end
    end

    initial begin
        rng_state     = 32'h9024_a0fb;
        checked_count = 0;
        clk           = 1'b0;
        rst           = 1'b1;
        fetch_slots   = '0;
        fetch_en      = '0;
        bpu_hints     = '0;
        pred_target   = '0;
        ctrl          = ctrl_idle;
        send_en       = '0;
        repeat (10) @(posedge clk);
        rst <= 1'b0;

        // in-order issue out of empty lanes
        repeat (3) drive_cycle(2'b11, hint_none, hint_not_taken, 2'b00, ctrl_idle);
        drain_lanes(40);

        // taken slot 0, shadow group, then a clean group
        drive_cycle(2'b11, hint_taken, hint_none, 2'b00, ctrl_idle);
        drive_cycle(2'b11, hint_none, hint_none, 2'b00, ctrl_idle);
        drive_cycle(2'b11, hint_none, hint_none, 2'b00, ctrl_idle);
        drain_lanes(40);

        // stalled fetch, then fill to full and keep offering
        repeat (4) drive_cycle(2'b11, hint_none, hint_none, 2'b00, ctrl_stall);
        fill_until_full(4 * `IBUF_DEPTH);
        repeat (3) drive_cycle(2'b11, hint_none, hint_none, 2'b00, ctrl_idle);
        drain_lanes(8 * `IBUF_DEPTH);

        // both pauses hold the heads
        repeat (3) drive_cycle(2'b11, hint_none, hint_none, 2'b00, ctrl_idle);
        repeat (5) drive_cycle(2'b00, hint_none, hint_none, 2'b11, 4'b0010);
        repeat (5) drive_cycle(2'b00, hint_none, hint_none, 2'b11, 4'b0001);
        drain_lanes(40);

        // flush drops queued entries and the shadow
        drive_cycle(2'b11, hint_none, hint_none, 2'b00, ctrl_idle);
        drive_cycle(2'b11, hint_taken, hint_none, 2'b00, ctrl_idle);
        drive_cycle(2'b11, hint_none, hint_none, 2'b00, ctrl_flush);
        drive_cycle(2'b11, hint_none, hint_none, 2'b00, ctrl_idle);
        drain_lanes(40);

        repeat (3000) drive_random();
        drain_lanes(200);

        if (checked_count < 500) begin
            stop_with_error($sformatf("only %0d entries issued during the run", checked_count));
        end else begin
            $display("TEST PASS");
            $finish;
        end
    end

endmodule

// File: sim.f
+incdir+hdl
+incdir+bench
hdl/fetch_pkg.sv
hdl/issue_pkg.sv
hdl/ibuf_fifo.sv
hdl/ibuf_push_ctrl.sv
hdl/ibuf_pop_ctrl.sv
hdl/inst_buffer.sv
bench/inst_buffer_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= inst_buffer_tb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
JOBS      ?= 4
VFLAGS    ?= --binary --timing --assert

BIN     := $(BUILD_DIR)/V$(TOP)
SOURCES := $(wildcard hdl/*.sv hdl/*.svh bench/*.sv bench/*.svh)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# exit status of the simulation is the test result
run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(BUILD_DIR)
